// ==== hdl/exu_pkg.sv ====
package exu_pkg;

  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_sle,
    alu_sleu
  } alu_op_e;

  typedef enum logic [2:0] {
    class_alu,
    class_branch,
    class_jal,
    class_jalr,
    class_load,
    class_store,
    class_system
  } op_class_e;

  typedef enum logic [2:0] {
    sys_priv,
    sys_csrrw,
    sys_csrrs,
    sys_csrrc,
    sys_csrrwi,
    sys_csrrsi,
    sys_csrrci
  } sys_func_e;

  // only meaningful when sys_func is sys_priv
  typedef enum logic [1:0] {
    priv_ecall,
    priv_ebreak,
    priv_mret
  } priv_e;

  // machine-mode csrs kept by the stage
  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec   = 12'h305;
  localparam csr_addr_t csr_mepc    = 12'h341;
  localparam csr_addr_t csr_mcause  = 12'h342;

  localparam word_t mcause_ecall_m = word_t'(11);

  // load/store sequencing in the issue block
  typedef enum logic [1:0] {
    mem_idle,
    mem_wait_resp,
    mem_done
  } mem_state_e;

endpackage

// ==== hdl/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  word_t   src1_i,
  input  word_t   src2_i,
  input  alu_op_e alu_op_i,
  output word_t   res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  // compares give 0 or 1, also used for branch decisions
  always_comb begin
    case (alu_op_i)
      alu_add:  res_o = src1_i + src2_i;
      alu_sub:  res_o = src1_i - src2_i;
      alu_sll:  res_o = src1_i << shamt;
      alu_slt:  res_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  res_o = src1_i ^ src2_i;
      alu_srl:  res_o = src1_i >> shamt;
      alu_sra:  res_o = word_t'($signed(src1_i) >>> shamt);
      alu_or:   res_o = src1_i | src2_i;
      alu_and:  res_o = src1_i & src2_i;
      alu_sle:  res_o = {{(xlen-1){1'b0}}, lt_s | eq};
      alu_sleu: res_o = {{(xlen-1){1'b0}}, lt_u | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

// ==== hdl/exu_issue.sv ====
`timescale 1ns/1ps

module exu_issue import exu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       op_valid_i,
  input  op_class_e  class_i,
  input  alu_op_e    alu_op_i,
  input  sys_func_e  sys_func_i,
  input  priv_e      priv_i,
  input  csr_addr_t  csr_addr_i,
  input  word_t      pc_i,
  input  word_t      src1_i,
  input  word_t      src2_i,
  input  word_t      imm_i,
  input  reg_idx_t   rd_i,
  input  logic       next_ready_i,
  input  logic       lsu_rvalid_i,
  input  logic       lsu_wready_i,
  input  word_t      lsu_rdata_i,
  output logic       op_ready_o,
  output logic       valid_o,
  output logic       retire_o,
  output logic       lsu_req_o,
  output logic       lsu_we_o,
  output word_t      lsu_addr_o,
  output word_t      lsu_wdata_o,
  output op_class_e  class_o,
  output alu_op_e    alu_op_o,
  output sys_func_e  sys_func_o,
  output priv_e      priv_o,
  output csr_addr_t  csr_addr_o,
  output word_t      pc_o,
  output word_t      src1_o,
  output word_t      src2_o,
  output word_t      imm_o,
  output reg_idx_t   rd_o,
  output word_t      mem_rdata_o
);

  mem_state_e mem_state;
  logic       alu_valid;
  logic       accept;
  logic       mem_op;
  logic       mem_resp;

  op_class_e  class_q;
  alu_op_e    alu_op_q;
  sys_func_e  sys_func_q;
  priv_e      priv_q;
  csr_addr_t  csr_addr_q;
  word_t      pc_q;
  word_t      src1_q;
  word_t      src2_q;
  word_t      imm_q;
  reg_idx_t   rd_q;
  word_t      mem_rdata_q;

  assign accept   = op_valid_i && op_ready_o;
  assign mem_op   = (class_i == class_load) || (class_i == class_store);
  assign mem_resp = (class_q == class_load) ? lsu_rvalid_i : lsu_wready_i;

  assign valid_o    = alu_valid || (mem_state == mem_done);
  assign retire_o   = valid_o && next_ready_i;
  // a retiring result frees the slot in the same cycle
  assign op_ready_o = (mem_state == mem_idle) && (!valid_o || next_ready_i);

  always_ff @(posedge clk) begin
    if (accept) begin
      class_q    <= class_i;
      alu_op_q   <= alu_op_i;
      sys_func_q <= sys_func_i;
      priv_q     <= priv_i;
      csr_addr_q <= csr_addr_i;
      pc_q       <= pc_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      imm_q      <= imm_i;
      rd_q       <= rd_i;
    end
    if (lsu_req_o && !lsu_we_o && lsu_rvalid_i) begin
      mem_rdata_q <= lsu_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid <= 1'b0;
      mem_state <= mem_idle;
    end else begin
      if (accept) begin
        alu_valid <= !mem_op;
      end else if (retire_o) begin
        alu_valid <= 1'b0;
      end
      case (mem_state)
        mem_idle:      if (accept && mem_op) mem_state <= mem_wait_resp;
        mem_wait_resp: if (mem_resp) mem_state <= mem_done;
        mem_done:      if (next_ready_i) mem_state <= mem_idle;
        default:       mem_state <= mem_idle;
      endcase
    end
  end

  assign lsu_req_o   = (mem_state == mem_wait_resp);
  assign lsu_we_o    = (class_q == class_store);
  assign lsu_addr_o  = src1_q + imm_q;
  assign lsu_wdata_o = src2_q;

  assign class_o     = class_q;
  assign alu_op_o    = alu_op_q;
  assign sys_func_o  = sys_func_q;
  assign priv_o      = priv_q;
  assign csr_addr_o  = csr_addr_q;
  assign pc_o        = pc_q;
  assign src1_o      = src1_q;
  assign src2_o      = src2_q;
  assign imm_o       = imm_q;
  assign rd_o        = rd_q;
  assign mem_rdata_o = mem_rdata_q;

  // held request keeps its address and data until the response
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    lsu_req_o && !mem_resp |=>
      lsu_req_o && $stable({lsu_we_o, lsu_addr_o, lsu_wdata_o}));

  a_no_valid_during_req: assert property (@(posedge clk) disable iff (rst)
    !(valid_o && lsu_req_o));

endmodule

// ==== hdl/exu_csr.sv ====
`timescale 1ns/1ps

module exu_csr import exu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       retire_i,
  input  op_class_e  class_i,
  input  sys_func_e  sys_func_i,
  input  priv_e      priv_i,
  input  csr_addr_t  csr_addr_i,
  input  word_t      src1_i,
  input  word_t      pc_i,
  output word_t      rdata_o,
  output word_t      mtvec_o,
  output word_t      mepc_o
);

  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t csr_old;
  word_t csr_wdata;
  logic  sys_retire;
  logic  is_priv;

  assign sys_retire = retire_i && (class_i == class_system);
  assign is_priv    = (sys_func_i == sys_priv);

  // unknown address reads as zero
  always_comb begin
    case (csr_addr_i)
      csr_mstatus: csr_old = mstatus_q;
      csr_mtvec:   csr_old = mtvec_q;
      csr_mepc:    csr_old = mepc_q;
      csr_mcause:  csr_old = mcause_q;
      default:     csr_old = '0;
    endcase
  end

  // immediate forms arrive zero-extended on src1
  always_comb begin
    case (sys_func_i)
      sys_csrrw, sys_csrrwi: csr_wdata = src1_i;
      sys_csrrs, sys_csrrsi: csr_wdata = csr_old | src1_i;
      sys_csrrc, sys_csrrci: csr_wdata = csr_old & ~src1_i;
      default:               csr_wdata = csr_old;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (sys_retire) begin
      if (is_priv) begin
        case (priv_i)
          priv_ecall: begin
            mepc_q   <= pc_i;
            mcause_q <= mcause_ecall_m;
          end
          priv_mret: begin
            // mpie back into mie, mpie set
            mstatus_q[3] <= mstatus_q[7];
            mstatus_q[7] <= 1'b1;
          end
          default: ;
        endcase
      end else begin
        case (csr_addr_i)
          csr_mstatus: mstatus_q <= csr_wdata;
          csr_mtvec:   mtvec_q   <= csr_wdata;
          csr_mepc:    mepc_q    <= csr_wdata;
          csr_mcause:  mcause_q  <= csr_wdata;
          default: ;
        endcase
      end
    end
  end

  assign rdata_o = csr_old;
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  a_csr_change_at_retire: assert property (@(posedge clk) disable iff (rst)
    !sys_retire |=> $stable({mstatus_q, mtvec_q, mepc_q, mcause_q}));

endmodule

// ==== hdl/exu_retire.sv ====
`timescale 1ns/1ps

module exu_retire import exu_pkg::*; (
  input  op_class_e  class_i,
  input  sys_func_e  sys_func_i,
  input  priv_e      priv_i,
  input  word_t      pc_i,
  input  word_t      src1_i,
  input  word_t      imm_i,
  input  alu_op_e    alu_op_i,
  input  word_t      alu_res_i,
  input  word_t      csr_rdata_i,
  input  word_t      mtvec_i,
  input  word_t      mepc_i,
  input  word_t      mem_rdata_i,
  input  logic       valid_i,
  output word_t      wdata_o,
  output word_t      npc_o,
  output logic       redirect_o,
  output logic       boundary_o,
  output logic       ebreak_o
);

  logic  is_priv;
  logic  is_ecall;
  logic  is_mret;
  logic  taken;
  word_t jalr_tgt;

  assign is_priv  = (class_i == class_system) && (sys_func_i == sys_priv);
  assign is_ecall = is_priv && (priv_i == priv_ecall);
  assign is_mret  = is_priv && (priv_i == priv_mret);
  assign jalr_tgt = src1_i + imm_i;

  // beq via sub, other branches via a nonzero compare
  always_comb begin
    case (alu_op_i)
      alu_sub:                                 taken = (alu_res_i == '0);
      alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu: taken = (alu_res_i != '0);
      default:                                 taken = 1'b0;
    endcase
  end

  always_comb begin
    case (class_i)
      class_load:           wdata_o = mem_rdata_i;
      class_system:         wdata_o = csr_rdata_i;
      class_jal, class_jalr: wdata_o = pc_i + word_t'(4);
      default:              wdata_o = alu_res_i;
    endcase
  end

  always_comb begin
    if (class_i == class_jalr) begin
      npc_o = {jalr_tgt[xlen-1:1], 1'b0};
    end else if (is_ecall) begin
      npc_o = mtvec_i;
    end else if (is_mret) begin
      npc_o = mepc_i;
    end else begin
      npc_o = pc_i + imm_i;
    end
  end

  assign redirect_o = valid_i && ((class_i == class_jal) || (class_i == class_jalr) ||
                                  is_ecall || is_mret ||
                                  ((class_i == class_branch) && taken));
  assign boundary_o = valid_i && ((class_i == class_system) || (class_i == class_branch) ||
                                  (class_i == class_load));
  assign ebreak_o   = valid_i && is_priv && (priv_i == priv_ebreak);

endmodule

// ==== hdl/exu_top.sv ====
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       op_valid_i,
  input  op_class_e  class_i,
  input  alu_op_e    alu_op_i,
  input  sys_func_e  sys_func_i,
  input  priv_e      priv_i,
  input  csr_addr_t  csr_addr_i,
  input  word_t      pc_i,
  input  word_t      src1_i,
  input  word_t      src2_i,
  input  word_t      imm_i,
  input  reg_idx_t   rd_i,
  output logic       op_ready_o,
  output logic       lsu_req_o,
  output logic       lsu_we_o,
  output word_t      lsu_addr_o,
  output word_t      lsu_wdata_o,
  input  logic       lsu_rvalid_i,
  input  logic       lsu_wready_i,
  input  word_t      lsu_rdata_i,
  input  logic       next_ready_i,
  output logic       valid_o,
  output reg_idx_t   rd_o,
  output word_t      wdata_o,
  output word_t      npc_o,
  output logic       redirect_o,
  output logic       boundary_o,
  output logic       ebreak_o
);

  op_class_e class_q;
  alu_op_e   alu_op_q;
  sys_func_e sys_func_q;
  priv_e     priv_q;
  csr_addr_t csr_addr_q;
  word_t     pc_q, src1_q, src2_q, imm_q, mem_rdata_q;
  word_t     alu_res, csr_rdata, mtvec, mepc;
  logic      retire;

  exu_issue i_exu_issue (
    .clk(clk), .rst(rst), .op_valid_i(op_valid_i), .class_i(class_i),
    .alu_op_i(alu_op_i), .sys_func_i(sys_func_i), .priv_i(priv_i),
    .csr_addr_i(csr_addr_i), .pc_i(pc_i), .src1_i(src1_i), .src2_i(src2_i),
    .imm_i(imm_i), .rd_i(rd_i), .next_ready_i(next_ready_i),
    .lsu_rvalid_i(lsu_rvalid_i), .lsu_wready_i(lsu_wready_i), .lsu_rdata_i(lsu_rdata_i),
    .op_ready_o(op_ready_o), .valid_o(valid_o), .retire_o(retire),
    .lsu_req_o(lsu_req_o), .lsu_we_o(lsu_we_o), .lsu_addr_o(lsu_addr_o),
    .lsu_wdata_o(lsu_wdata_o), .class_o(class_q), .alu_op_o(alu_op_q),
    .sys_func_o(sys_func_q), .priv_o(priv_q), .csr_addr_o(csr_addr_q), .pc_o(pc_q),
    .src1_o(src1_q), .src2_o(src2_q), .imm_o(imm_q), .rd_o(rd_o),
    .mem_rdata_o(mem_rdata_q)
  );

  exu_alu i_exu_alu (
    .src1_i(src1_q), .src2_i(src2_q), .alu_op_i(alu_op_q), .res_o(alu_res)
  );

  exu_csr i_exu_csr (
    .clk(clk), .rst(rst), .retire_i(retire), .class_i(class_q), .sys_func_i(sys_func_q),
    .priv_i(priv_q), .csr_addr_i(csr_addr_q), .src1_i(src1_q), .pc_i(pc_q),
    .rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_retire i_exu_retire (
    .class_i(class_q), .sys_func_i(sys_func_q), .priv_i(priv_q), .pc_i(pc_q),
    .src1_i(src1_q), .imm_i(imm_q), .alu_op_i(alu_op_q), .alu_res_i(alu_res),
    .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc), .mem_rdata_i(mem_rdata_q),
    .valid_i(valid_o), .wdata_o(wdata_o), .npc_o(npc_o), .redirect_o(redirect_o),
    .boundary_o(boundary_o), .ebreak_o(ebreak_o)
  );

endmodule

// ==== dv/exu_ref.svh ====
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// one accepted operation as the model keeps it
typedef struct packed {
  op_class_e cls;
  alu_op_e   alu_op;
  sys_func_e func;
  priv_e     priv;
  csr_addr_t csr;
  word_t     pc;
  word_t     src1;
  word_t     src2;
  word_t     imm;
  reg_idx_t  rd;
} op_t;

// model csr state, updated at each observed retire
word_t m_mstatus, m_mtvec, m_mepc, m_mcause;

function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
  case (op)
    alu_add:  return a + b;
    alu_sub:  return a - b;
    alu_sll:  return a << b[4:0];
    alu_slt:  return word_t'($signed(a) < $signed(b));
    alu_sltu: return word_t'(a < b);
    alu_xor:  return a ^ b;
    alu_srl:  return a >> b[4:0];
    alu_sra:  return word_t'($signed(a) >>> b[4:0]);
    alu_or:   return a | b;
    alu_and:  return a & b;
    alu_sle:  return word_t'($signed(a) <= $signed(b));
    alu_sleu: return word_t'(a <= b);
    default:  return '0;
  endcase
endfunction

function automatic logic is_mem(op_t op);
  return (op.cls == class_load) || (op.cls == class_store);
endfunction

function automatic logic is_priv(op_t op, priv_e p);
  return (op.cls == class_system) && (op.func == sys_priv) && (op.priv == p);
endfunction

function automatic word_t csr_read(csr_addr_t addr);
  case (addr)
    csr_mstatus: return m_mstatus;
    csr_mtvec:   return m_mtvec;
    csr_mepc:    return m_mepc;
    csr_mcause:  return m_mcause;
    default:     return '0;
  endcase
endfunction

// beq is sub with a zero result, the other branch codes want nonzero
function automatic logic branch_taken(op_t op);
  word_t res;
  res = alu_model(op.alu_op, op.src1, op.src2);
  return (op.alu_op == alu_sub) ? (res == '0) : (res != '0);
endfunction

function automatic word_t expect_wdata(op_t op, word_t mem);
  case (op.cls)
    class_load:            return mem;
    class_system:          return csr_read(op.csr);
    class_jal, class_jalr: return op.pc + 32'd4;
    default:               return alu_model(op.alu_op, op.src1, op.src2);
  endcase
endfunction

function automatic word_t expect_npc(op_t op);
  if (op.cls == class_jalr) return (op.src1 + op.imm) & ~32'd1;
  if (is_priv(op, priv_ecall)) return m_mtvec;
  if (is_priv(op, priv_mret)) return m_mepc;
  return op.pc + op.imm;
endfunction

function automatic logic expect_redirect(op_t op);
  case (op.cls)
    class_jal, class_jalr: return 1'b1;
    class_branch:          return branch_taken(op);
    default:               return is_priv(op, priv_ecall) || is_priv(op, priv_mret);
  endcase
endfunction

function automatic void csr_apply(op_t op);
  word_t old;
  word_t nv;
  old = csr_read(op.csr);
  case (op.func)
    sys_csrrw, sys_csrrwi: nv = op.src1;
    sys_csrrs, sys_csrrsi: nv = old | op.src1;
    sys_csrrc, sys_csrrci: nv = old & ~op.src1;
    default:               nv = old;
  endcase
  if (op.cls != class_system) return;
  if (is_priv(op, priv_ecall)) begin
    m_mepc   = op.pc;
    m_mcause = 32'd11;
  end else if (is_priv(op, priv_mret)) begin
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
  end else if (op.func != sys_priv) begin
    case (op.csr)
      csr_mstatus: m_mstatus = nv;
      csr_mtvec:   m_mtvec   = nv;
      csr_mepc:    m_mepc    = nv;
      csr_mcause:  m_mcause  = nv;
      default: ;
    endcase
  end
endfunction

// load data pattern over the whole address
function automatic word_t load_data(word_t addr);
  return {addr[7:0], addr[31:8]} ^ 32'h9e37_79b9;
endfunction

`endif

// ==== dv/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      op_valid_i;
  op_class_e class_i;
  alu_op_e   alu_op_i;
  sys_func_e sys_func_i;
  priv_e     priv_i;
  csr_addr_t csr_addr_i;
  word_t     pc_i, src1_i, src2_i, imm_i;
  reg_idx_t  rd_i;
  logic      next_ready_i, lsu_rvalid_i, lsu_wready_i;
  word_t     lsu_rdata_i;
  logic      op_ready_o, lsu_req_o, lsu_we_o, valid_o;
  logic      redirect_o, boundary_o, ebreak_o;
  word_t     lsu_addr_o, lsu_wdata_o, wdata_o, npc_o;
  reg_idx_t  rd_o;

  `include "exu_ref.svh"

  integer      seed;
  op_t         pend_q[$];
  int          n_acc, n_ret, idle_cycles, req_count, drain;
  int unsigned lsu_delay;
  logic        lsu_busy, resp_seen, prev_req, hold_chk, held_redirect;
  word_t       resp_data, held_wdata, held_npc;

  alu_op_e   br_ops[6] = '{alu_sub, alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu};
  csr_addr_t csr_pick[5] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, 12'h7c0};

  exu_top i_exu_top (.*);

  always #4 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic drive_inputs(input logic allow_new);
    word_t r;
    r            = $random(seed);
    op_valid_i   = allow_new && (rand_below(10) < 7);
    next_ready_i = rand_below(10) < 7;
    class_i      = op_class_e'(3'(rand_below(7)));
    alu_op_i     = alu_op_e'(4'(rand_below(12)));
    if (class_i == class_branch) alu_op_i = br_ops[3'(rand_below(6))];
    sys_func_i   = sys_func_e'(3'(rand_below(7)));
    priv_i       = priv_e'(2'(rand_below(3)));
    csr_addr_i   = csr_pick[3'(rand_below(5))];
    pc_i         = word_t'($random(seed)) & 32'hffff_fffc;
    imm_i        = {{20{r[11]}}, r[11:0]};
    rd_i         = r[16:12];
    src1_i       = $random(seed);
    src2_i       = (rand_below(4) == 0) ? src1_i : word_t'($random(seed));
    // immediate csr forms carry a zero-extended 5-bit value
    if (sys_func_i inside {sys_csrrwi, sys_csrrsi, sys_csrrci}) begin
      src1_i = word_t'(rand_below(32));
    end
  endtask

  // fake load/store unit, one response pulse after 0 to 4 cycles
  task automatic drive_lsu();
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    lsu_rdata_i  = $random(seed);
    if (lsu_req_o && !lsu_busy) begin
      lsu_busy  = 1'b1;
      lsu_delay = rand_below(5);
    end
    if (lsu_busy) begin
      if (lsu_delay == 0) begin
        lsu_busy = 1'b0;
        if (lsu_we_o) begin
          lsu_wready_i = 1'b1;
        end else begin
          lsu_rvalid_i = 1'b1;
          lsu_rdata_i  = load_data(lsu_addr_o);
        end
      end else begin
        lsu_delay--;
      end
    end
  endtask

  task automatic sample_outputs();
    op_t  head;
    op_t  entry;
    logic have;
    logic exp_valid;
    have = pend_q.size() > 0;
    if (have) head = pend_q[0];
    exp_valid = have && (!is_mem(head) || resp_seen);
    check_val("valid_o", word_t'(valid_o), word_t'(exp_valid));
    check_val("op_ready_o", word_t'(op_ready_o),
              word_t'(!(have && is_mem(head)) && !(exp_valid && !next_ready_i)));
    check_val("lsu_req_o", word_t'(lsu_req_o), word_t'(have && is_mem(head) && !resp_seen));
    if (lsu_req_o) begin
      check_val("lsu_addr_o", lsu_addr_o, head.src1 + head.imm);
      check_val("lsu_wdata_o", lsu_wdata_o, head.src2);
      check_val("lsu_we_o", word_t'(lsu_we_o), word_t'(head.cls == class_store));
      if (!prev_req) req_count++;
      if (lsu_we_o ? lsu_wready_i : lsu_rvalid_i) begin
        resp_seen = 1'b1;
        resp_data = lsu_rdata_i;
      end
    end
    prev_req = lsu_req_o;
    // result must hold while the next stage stalls
    if (hold_chk) begin
      check_val("held wdata_o", wdata_o, held_wdata);
      check_val("held npc_o", npc_o, held_npc);
      check_val("held redirect_o", word_t'(redirect_o), word_t'(held_redirect));
    end
    hold_chk      = valid_o && !next_ready_i;
    held_wdata    = wdata_o;
    held_npc      = npc_o;
    held_redirect = redirect_o;
    check_val("redirect_o", word_t'(redirect_o), word_t'(exp_valid && expect_redirect(head)));
    check_val("boundary_o", word_t'(boundary_o), word_t'(exp_valid &&
              (head.cls inside {class_system, class_branch, class_load})));
    check_val("ebreak_o", word_t'(ebreak_o), word_t'(exp_valid && is_priv(head, priv_ebreak)));
    if (exp_valid) begin
      check_val("rd_o", word_t'(rd_o), word_t'(head.rd));
      check_val("wdata_o", wdata_o, expect_wdata(head, resp_data));
      check_val("npc_o", npc_o, expect_npc(head));
    end
    if (exp_valid && next_ready_i) begin
      if (is_mem(head)) check_val("lsu request count", word_t'(req_count), 32'd1);
      csr_apply(head);
      void'(pend_q.pop_front());
      n_ret++;
      idle_cycles = 0;
      resp_seen   = 1'b0;
      req_count   = 0;
    end
    if (op_valid_i && op_ready_o) begin
      entry = '{class_i, alu_op_i, sys_func_i, priv_i, csr_addr_i, pc_i,
                src1_i, src2_i, imm_i, rd_i};
      pend_q.push_back(entry);
      n_acc++;
    end
  endtask

  task automatic run_cycle(input logic allow_new);
    @(negedge clk);
    drive_inputs(allow_new);
    drive_lsu();
    #2;
    sample_outputs();
    idle_cycles++;
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    seed         = 53;
    op_valid_i   = 1'b0;
    class_i      = class_alu;
    alu_op_i     = alu_add;
    sys_func_i   = sys_priv;
    priv_i       = priv_ecall;
    csr_addr_i   = '0;
    pc_i         = '0;
    src1_i       = '0;
    src2_i       = '0;
    imm_i        = '0;
    rd_i         = '0;
    next_ready_i = 1'b0;
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    lsu_rdata_i  = '0;
    m_mstatus    = '0;
    m_mtvec      = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    n_acc        = 0;
    n_ret        = 0;
    idle_cycles  = 0;
    req_count    = 0;
    lsu_busy     = 1'b0;
    resp_seen    = 1'b0;
    prev_req     = 1'b0;
    hold_chk     = 1'b0;
    resp_data    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (n_ret < 3000) begin
      run_cycle(1'b1);
      if (idle_cycles > 200) fail_run("timeout: no operation retired within 200 cycles");
    end
    // stop issuing and let the last operation leave
    drain = 0;
    while (pend_q.size() > 0) begin
      run_cycle(1'b0);
      drain++;
      if (drain > 200) fail_run("timeout: pending operation did not retire after issue stopped");
    end
    if (n_acc == n_ret) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run("accepted and retired operation counts differ");
    end
  end

endmodule

// ==== tb.f ====
+incdir+dv
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_issue.sv
hdl/exu_csr.sv
hdl/exu_retire.sv
hdl/exu_top.sv
dv/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f tb.f --top-module exu_tb -o exu_sim
./obj_dir/exu_sim
